//--- dv/qe_channel_asserts.sv
// Channel timing assertions

`timescale 1ns/1ps
`default_nettype none

module qe_channel_asserts (
    input logic clk,
    input logic reset,
    input logic step,
    input logic rd_strobe,
    input logic rd_valid
);

    // decoder step pulses last a single cycle
    a_step_single: assert property (@(posedge clk) disable iff (!reset) step |=> !step)
        else $error("step high on two consecutive cycles");

    // read response exactly one cycle after the strobe
    a_rd_valid_set: assert property (@(posedge clk) disable iff (!reset)
                                     rd_strobe |=> rd_valid)
        else $error("rd_valid missing one cycle after rd_strobe");

    a_rd_valid_clr: assert property (@(posedge clk) disable iff (!reset)
                                     !rd_strobe |=> !rd_valid)
        else $error("rd_valid without a read strobe");

endmodule

bind qe_channel qe_channel_asserts u_asserts (
    .clk(clk), .reset(reset), .step(step),
    .rd_strobe(rd_strobe), .rd_valid(rd_valid)
);

`default_nettype wire

//--- dv/qe_channel_tb.sv
// Quadrature encoder channel testbench

`timescale 1ns/1ps
`default_nettype none

`include "qe_config.svh"

module qe_channel_tb
    import qe_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 50;
    localparam int STEP_SETTLE    = 8;

    logic                  clk;
    logic                  reset;
    logic                  ext_a;
    logic                  ext_b;
    logic                  ext_i;
    logic                  wr_strobe;
    logic                  rd_strobe;
    logic [`QE_ADDR_W-1:0] addr;
    qe_word_t              wr_data;
    qe_word_t              rd_data;
    logic                  rd_valid;

    // expectations queued with each read strobe
    qe_word_t exp_q[$];
    string    name_q[$];
    bit       care_q[$];
    qe_word_t last_rd;
    int       rd_count;
    int       check_count;
    int       error_count;
    int       test_count;
    int       failed_tests;
    int       test_err_base;

    // reference model state
    int       ref_pos;
    int       ref_turns;
    logic     ref_dir;
    logic     ref_enable;
    logic     ref_flip;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    qe_channel dut (
        .clk(clk), .reset(reset),
        .ext_a(ext_a), .ext_b(ext_b), .ext_i(ext_i),
        .wr_strobe(wr_strobe), .rd_strobe(rd_strobe), .addr(addr), .wr_data(wr_data),
        .rd_data(rd_data), .rd_valid(rd_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // one of A/B changes and counts up when new A differs from old B
    function automatic int ref_step(logic oa, logic ob, logic na, logic nb);
        if ((oa ^ na) == (ob ^ nb)) begin
            return 0;
        end
        return (na ^ ob) ? 1 : -1;
    endfunction

    // turns expected from the simulated encoder for position p
    function automatic int ref_sim_turns(int p, int k);
        if (p >= 0) begin
            return p / k;
        end
        return -((-p) / k);
    endfunction

    function automatic qe_word_t ref_status();
        qe_word_t s;
        s    = '0;
        s[0] = ref_flip ? ext_b : ext_a;
        s[1] = ref_flip ? ext_a : ext_b;
        s[2] = ext_i;
        s[3] = ref_dir;
        return s;
    endfunction

    function automatic string reg_name(logic [`QE_ADDR_W-1:0] a);
        case (a)
            `QE_REG_COUNT:          return "count";
            `QE_REG_TURNS:          return "turns";
            `QE_REG_PHASE_TIME:     return "phase_time";
            `QE_REG_COUNTS_PER_REV: return "counts_per_rev";
            `QE_REG_CONFIG:         return "config";
            `QE_REG_STATUS:         return "status";
            default:                return "unused";
        endcase
    endfunction

    // arguments are the levels as the decoder sees them
    task automatic ref_update(logic oa, logic ob, logic na, logic nb);
        int d;
        d = ref_step(oa, ob, na, nb);
        if (d != 0) begin
            ref_dir = (d > 0);
            if (ref_enable) begin
                ref_pos += d;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checking and reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(string name, qe_word_t got, qe_word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    always @(negedge clk) begin : compare_reads
        qe_word_t exp;
        string    name;
        bit       care;
        if (reset && rd_valid) begin
            if (exp_q.size() == 0) begin
                $display("error: read data returned with no read pending");
                error_count++;
            end else begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                care = care_q.pop_front();
                if (care) begin
                    check_value(name, rd_data, exp);
                end
            end
            last_rd = rd_data;
            rd_count++;
        end
    end

    task automatic end_test(string name);
        int errs;
        errs = error_count - test_err_base;
        test_count++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, errs);
            failed_tests++;
        end
        test_err_base = error_count;
    endtask

    task automatic abort_run(string why);
        $display("error: %s", why);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset      = 1'b0;
        ext_a      = 1'b0;
        ext_b      = 1'b0;
        ext_i      = 1'b0;
        wr_strobe  = 1'b0;
        rd_strobe  = 1'b0;
        addr       = '0;
        wr_data    = '0;
        ref_pos    = 0;
        ref_turns  = 0;
        ref_dir    = 1'b0;
        ref_enable = 1'b0;
        ref_flip   = 1'b0;
        wait_cycles(3);
        reset = 1'b1;
    endtask

    task automatic bus_write(logic [`QE_ADDR_W-1:0] a, qe_word_t d);
        @(negedge clk);
        wr_strobe = 1'b1;
        addr      = a;
        wr_data   = d;
        @(negedge clk);
        wr_strobe = 1'b0;
    endtask

    task automatic bus_read(logic [`QE_ADDR_W-1:0] a, bit care, qe_word_t exp,
                            output qe_word_t data);
        int target;
        int n;
        target = rd_count + 1;
        exp_q.push_back(exp);
        name_q.push_back(reg_name(a));
        care_q.push_back(care);
        @(negedge clk);
        rd_strobe = 1'b1;
        addr      = a;
        @(negedge clk);
        rd_strobe = 1'b0;
        n = 0;
        while (rd_count < target && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (rd_count < target) begin
            abort_run($sformatf("no read response from %s", reg_name(a)));
        end else begin
            data = last_rd;
        end
    endtask

    task automatic read_check(logic [`QE_ADDR_W-1:0] a, qe_word_t exp);
        qe_word_t unused;
        bus_read(a, 1'b1, exp, unused);
    endtask

    task automatic write_config(logic en, logic src, logic sim_en, logic sim_rev,
                                logic flip);
        qe_word_t w;
        logic     oa;
        logic     ob;
        logic     na;
        logic     nb;
        w                      = '0;
        w[`QE_CFG_ENABLE]      = en;
        w[`QE_CFG_SOURCE]      = src;
        w[`QE_CFG_SIM_ENABLE]  = sim_en;
        w[`QE_CFG_SIM_DIR]     = sim_rev;
        w[`QE_CFG_FLIP_AB]     = flip;
        // a swap is seen by the decoder as an input change
        oa         = ref_flip ? ext_b : ext_a;
        ob         = ref_flip ? ext_a : ext_b;
        na         = flip ? ext_b : ext_a;
        nb         = flip ? ext_a : ext_b;
        ref_enable = en;
        ref_flip   = flip;
        ref_update(oa, ob, na, nb);
        bus_write(`QE_REG_CONFIG, w);
    endtask

    // pins walk AB 00, 10, 11, 01 going forward
    task automatic ext_step(bit forward);
        logic [1:0] ph;
        logic       na;
        logic       nb;
        ph = {ext_b, ext_a ^ ext_b};
        ph = forward ? ph + 2'd1 : ph - 2'd1;
        na = ph[1] ^ ph[0];
        nb = ph[1];
        if (ref_flip) begin
            ref_update(ext_b, ext_a, nb, na);
        end else begin
            ref_update(ext_a, ext_b, na, nb);
        end
        @(negedge clk);
        ext_a = na;
        ext_b = nb;
        wait_cycles(STEP_SETTLE);
    endtask

    task automatic ext_index();
        if (ref_enable) begin
            ref_turns += ref_dir ? 1 : -1;
        end
        @(negedge clk);
        ext_i = 1'b1;
        wait_cycles(STEP_SETTLE);
        @(negedge clk);
        ext_i = 1'b0;
        wait_cycles(STEP_SETTLE);
    endtask

    task automatic run_sim(logic reverse, int k);
        qe_word_t p;
        int       run;
        apply_reset();
        bus_write(`QE_REG_PHASE_TIME, 32'd1);
        bus_write(`QE_REG_COUNTS_PER_REV, qe_word_t'(k));
        write_config(1'b1, 1'b1, 1'b1, reverse, 1'b0);
        run = 200 + $urandom % 200;
        wait_cycles(run);
        write_config(1'b1, 1'b1, 1'b0, reverse, 1'b0);
        wait_cycles(10);
        bus_read(`QE_REG_COUNT, 1'b0, '0, p);
        if (reverse ? int'(p) >= 0 : int'(p) <= 0) begin
            $display("error: simulated encoder did not count in the selected direction");
            error_count++;
        end
        read_check(`QE_REG_TURNS, qe_word_t'(ref_sim_turns(int'(p), k)));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main_sequence
        int       n_fwd;
        int       n_rev;
        int       k;
        qe_word_t w;
        reset       = 1'b0;
        ext_a       = 1'b0;
        ext_b       = 1'b0;
        ext_i       = 1'b0;
        wr_strobe   = 1'b0;
        rd_strobe   = 1'b0;
        addr        = '0;
        wr_data     = '0;
        rd_count    = 0;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        failed_tests  = 0;
        test_err_base = 0;
        void'($urandom(32'hfc4a_2cea));

        apply_reset();
        for (int r = 0; r < 8; r++) begin
            read_check(3'(r), '0);
        end
        bus_write(`QE_REG_STATUS, $urandom());
        bus_write(3'd6, $urandom());
        bus_write(3'd7, $urandom());
        read_check(`QE_REG_STATUS, '0);
        read_check(3'd6, '0);
        read_check(3'd7, '0);
        w = $urandom();
        bus_write(`QE_REG_PHASE_TIME, w);
        read_check(`QE_REG_PHASE_TIME, w);
        w = $urandom();
        bus_write(`QE_REG_COUNTS_PER_REV, w);
        read_check(`QE_REG_COUNTS_PER_REV, w);
        w = $urandom();
        bus_write(`QE_REG_CONFIG, w);
        read_check(`QE_REG_CONFIG, w);
        end_test("reset and readback");

        apply_reset();
        write_config(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        n_fwd = 2 + $urandom % 20;
        n_rev = 1 + $urandom % (n_fwd - 1);
        repeat (n_fwd) ext_step(1'b1);
        repeat (n_rev) ext_step(1'b0);
        read_check(`QE_REG_COUNT, qe_word_t'(ref_pos));
        write_config(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (n_fwd) ext_step(1'b1);
        repeat (n_rev) ext_step(1'b0);
        read_check(`QE_REG_COUNT, qe_word_t'(ref_pos));
        read_check(`QE_REG_STATUS, ref_status());
        end_test("external counting");

        write_config(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (1 + $urandom % 8) ext_step(1'b1);
        repeat (1 + $urandom % 4) ext_index();
        repeat (1 + $urandom % 8) ext_step(1'b0);
        repeat (1 + $urandom % 4) ext_index();
        read_check(`QE_REG_TURNS, qe_word_t'(ref_turns));
        read_check(`QE_REG_COUNT, qe_word_t'(ref_pos));
        end_test("index and turns");

        write_config(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (5) ext_step(1'b1);
        repeat (2) ext_index();
        read_check(`QE_REG_COUNT, qe_word_t'(ref_pos));
        read_check(`QE_REG_TURNS, qe_word_t'(ref_turns));
        w = $urandom();
        bus_write(`QE_REG_COUNT, w);
        ref_pos = int'(w);
        read_check(`QE_REG_COUNT, w);
        w = $urandom();
        bus_write(`QE_REG_TURNS, w);
        ref_turns = int'(w);
        read_check(`QE_REG_TURNS, w);
        write_config(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        repeat (1 + $urandom % 10) ext_step(1'b1);
        read_check(`QE_REG_COUNT, qe_word_t'(ref_pos));
        end_test("enable and preload");

        k = 3 + $urandom % 5;
        run_sim(1'b0, k);
        end_test("simulated encoder forward");
        run_sim(1'b1, k);
        end_test("simulated encoder reverse");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/qe_pkg.sv
hw/qe_input_select.sv
hw/qe_decoder.sv
hw/qe_counters.sv
hw/qe_sim_generator.sv
hw/qe_regs.sv
hw/qe_channel.sv
dv/qe_channel_asserts.sv
dv/qe_channel_tb.sv

//--- hw/qe_channel.sv
// Quadrature encoder channel

`timescale 1ns/1ps
`default_nettype none

`include "qe_config.svh"

module qe_channel
    import qe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ext_a,
    input  logic                  ext_b,
    input  logic                  ext_i,
    input  logic                  wr_strobe,
    input  logic                  rd_strobe,
    input  logic [`QE_ADDR_W-1:0] addr,
    input  qe_word_t              wr_data,
    output qe_word_t              rd_data,
    output logic                  rd_valid
);

    logic     enable, source, sim_enable, sim_dir, flip_ab;
    qe_word_t phase_time, counts_per_rev;
    logic     load_count, load_turns;
    qe_word_t load_value;
    qe_word_t position, turns;
    logic     sim_a, sim_b, sim_i;
    logic     qe_a, qe_b, qe_i;
    logic     step, index, direction;

    qe_regs u_regs (
        .clk(clk), .reset(reset),
        .wr_strobe(wr_strobe), .rd_strobe(rd_strobe), .addr(addr), .wr_data(wr_data),
        .position(position), .turns(turns),
        .qe_a(qe_a), .qe_b(qe_b), .qe_i(qe_i), .direction(direction),
        .rd_data(rd_data), .rd_valid(rd_valid),
        .enable(enable), .source(source), .sim_enable(sim_enable),
        .sim_dir(sim_dir), .flip_ab(flip_ab),
        .phase_time(phase_time), .counts_per_rev(counts_per_rev),
        .load_count(load_count), .load_turns(load_turns), .load_value(load_value)
    );

    qe_sim_generator u_sim (
        .clk(clk), .reset(reset),
        .sim_enable(sim_enable), .sim_dir(sim_dir),
        .phase_time(phase_time), .counts_per_rev(counts_per_rev),
        .sim_a(sim_a), .sim_b(sim_b), .sim_i(sim_i)
    );

    qe_input_select u_input (
        .clk(clk), .reset(reset),
        .ext_a(ext_a), .ext_b(ext_b), .ext_i(ext_i),
        .sim_a(sim_a), .sim_b(sim_b), .sim_i(sim_i),
        .source(source), .flip_ab(flip_ab),
        .qe_a(qe_a), .qe_b(qe_b), .qe_i(qe_i)
    );

    qe_decoder u_decoder (
        .clk(clk), .reset(reset),
        .qe_a(qe_a), .qe_b(qe_b), .qe_i(qe_i),
        .step(step), .index(index), .direction(direction)
    );

    qe_counters u_counters (
        .clk(clk), .reset(reset), .enable(enable),
        .step(step), .index(index), .direction(direction),
        .load_count(load_count), .load_turns(load_turns), .load_value(load_value),
        .position(position), .turns(turns)
    );

endmodule

`default_nettype wire

//--- hw/qe_config.svh
// Quadrature encoder channel constants

`ifndef QE_CONFIG_SVH
`define QE_CONFIG_SVH

// register word and local address widths
`define QE_WORD_W               32
`define QE_ADDR_W               3

// register offsets within the channel
`define QE_REG_COUNT            3'd0
`define QE_REG_TURNS            3'd1
`define QE_REG_PHASE_TIME       3'd2
`define QE_REG_COUNTS_PER_REV   3'd3
`define QE_REG_CONFIG           3'd4
`define QE_REG_STATUS           3'd5

// configuration register bit positions
`define QE_CFG_ENABLE           0
`define QE_CFG_SOURCE           1
`define QE_CFG_SIM_ENABLE       2
`define QE_CFG_SIM_DIR          3
`define QE_CFG_FLIP_AB          4

// input synchroniser depth and quadrature phases per cycle
`define QE_SYNC_STAGES          2
`define QE_NUM_PHASES           4

`endif

//--- hw/qe_counters.sv
// Position and turns counters

`timescale 1ns/1ps
`default_nettype none

module qe_counters
    import qe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  logic     step,
    input  logic     index,
    input  logic     direction,
    input  logic     load_count,
    input  logic     load_turns,
    input  qe_word_t load_value,
    output qe_word_t position,
    output qe_word_t turns
);

    ////////////////////////////////////////////////////////////////////////////
    // position, one count per decoded step
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            position <= '0;
        end else if (load_count) begin
            // bus preload wins over a step in the same cycle
            position <= load_value;
        end else if (enable && step) begin
            position <= direction ? position + 1'b1 : position - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // turns, one count per index edge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            turns <= '0;
        end else if (load_turns) begin
            turns <= load_value;
        end else if (enable && index) begin
            // sense follows the last step seen
            turns <= direction ? turns + 1'b1 : turns - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/qe_decoder.sv
// Quadrature step and index decoder

`timescale 1ns/1ps
`default_nettype none

module qe_decoder (
    input  logic clk,
    input  logic reset,
    input  logic qe_a,
    input  logic qe_b,
    input  logic qe_i,
    output logic step,
    output logic index,
    output logic direction
);

    // levels seen on the previous cycle
    logic a_q;
    logic b_q;
    logic i_q;

    logic a_chg;
    logic b_chg;
    logic one_chg;

    assign a_chg   = qe_a ^ a_q;
    assign b_chg   = qe_b ^ b_q;

    // both edges together is an illegal transition and is dropped
    assign one_chg = a_chg ^ b_chg;

    ////////////////////////////////////////////////////////////////////////////
    // history and step / index pulses
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            a_q       <= 1'b0;
            b_q       <= 1'b0;
            i_q       <= 1'b0;
            step      <= 1'b0;
            index     <= 1'b0;
            direction <= 1'b0;
        end else begin
            a_q   <= qe_a;
            b_q   <= qe_b;
            i_q   <= qe_i;
            step  <= one_chg;
            index <= qe_i & ~i_q;
            // up when new A differs from old B, held until the next step
            if (one_chg) begin
                direction <= qe_a ^ b_q;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/qe_input_select.sv
// Encoder input source selection

`timescale 1ns/1ps
`default_nettype none

`include "qe_config.svh"

module qe_input_select (
    input  logic clk,
    input  logic reset,
    input  logic ext_a,
    input  logic ext_b,
    input  logic ext_i,
    input  logic sim_a,
    input  logic sim_b,
    input  logic sim_i,
    input  logic source,
    input  logic flip_ab,
    output logic qe_a,
    output logic qe_b,
    output logic qe_i
);

    // {i, b, a} per stage, stage 0 samples the pins
    logic [2:0] sync_q [`QE_SYNC_STAGES];
    logic [2:0] sel;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int s = 0; s < `QE_SYNC_STAGES; s++) begin
                sync_q[s] <= 3'b000;
            end
        end else begin
            sync_q[0] <= {ext_i, ext_b, ext_a};
            for (int s = 1; s < `QE_SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    // source 1 picks the internal generator
    assign sel  = source ? {sim_i, sim_b, sim_a} : sync_q[`QE_SYNC_STAGES-1];

    assign qe_a = flip_ab ? sel[1] : sel[0];
    assign qe_b = flip_ab ? sel[0] : sel[1];
    assign qe_i = sel[2];

endmodule

`default_nettype wire

//--- hw/qe_pkg.sv
// Quadrature encoder channel types

`default_nettype none

`include "qe_config.svh"

package qe_pkg;

    // one bus register word
    typedef logic [`QE_WORD_W-1:0] qe_word_t;

    // control fields, msb first so each lands on its QE_CFG_* bit
    typedef struct packed {
        logic [26:0] reserved;
        logic        flip_ab;
        logic        sim_dir;
        logic        sim_enable;
        logic        source;
        logic        enable;
    } qe_config_fields_t;

    // config register seen as a raw bus word or as decoded fields
    typedef union packed {
        qe_word_t          raw;
        qe_config_fields_t fields;
    } qe_config_u;

endpackage

`default_nettype wire

//--- hw/qe_regs.sv
// Channel register block

`timescale 1ns/1ps
`default_nettype none

`include "qe_config.svh"

module qe_regs
    import qe_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_strobe,
    input  logic                  rd_strobe,
    input  logic [`QE_ADDR_W-1:0] addr,
    input  qe_word_t              wr_data,
    input  qe_word_t              position,
    input  qe_word_t              turns,
    input  logic                  qe_a,
    input  logic                  qe_b,
    input  logic                  qe_i,
    input  logic                  direction,
    output qe_word_t              rd_data,
    output logic                  rd_valid,
    output logic                  enable,
    output logic                  source,
    output logic                  sim_enable,
    output logic                  sim_dir,
    output logic                  flip_ab,
    output qe_word_t              phase_time,
    output qe_word_t              counts_per_rev,
    output logic                  load_count,
    output logic                  load_turns,
    output qe_word_t              load_value
);

    qe_config_u cfg_q;
    qe_word_t   status;
    qe_word_t   rd_mux;

    ////////////////////////////////////////////////////////////////////////////
    // write decode
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase_time     <= '0;
            counts_per_rev <= '0;
            cfg_q          <= '0;
        end else if (wr_strobe) begin
            case (addr)
                `QE_REG_PHASE_TIME:     phase_time     <= wr_data;
                `QE_REG_COUNTS_PER_REV: counts_per_rev <= wr_data;
                `QE_REG_CONFIG:         cfg_q.raw      <= wr_data;
                default: ;
            endcase
        end
    end

    // counters live in qe_counters, loaded on the strobe edge
    assign load_count = wr_strobe && (addr == `QE_REG_COUNT);
    assign load_turns = wr_strobe && (addr == `QE_REG_TURNS);
    assign load_value = wr_data;

    assign enable     = cfg_q.fields.enable;
    assign source     = cfg_q.fields.source;
    assign sim_enable = cfg_q.fields.sim_enable;
    assign sim_dir    = cfg_q.fields.sim_dir;
    assign flip_ab    = cfg_q.fields.flip_ab;

    ////////////////////////////////////////////////////////////////////////////
    // status and read path
    ////////////////////////////////////////////////////////////////////////////

    assign status = {28'd0, direction, qe_i, qe_b, qe_a};

    always_comb begin
        case (addr)
            `QE_REG_COUNT:          rd_mux = position;
            `QE_REG_TURNS:          rd_mux = turns;
            `QE_REG_PHASE_TIME:     rd_mux = phase_time;
            `QE_REG_COUNTS_PER_REV: rd_mux = counts_per_rev;
            `QE_REG_CONFIG:         rd_mux = cfg_q.raw;
            `QE_REG_STATUS:         rd_mux = status;
            default:                rd_mux = '0;
        endcase
    end

    // data one cycle after the read strobe
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_data  <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_strobe;
            if (rd_strobe) begin
                rd_data <= rd_mux;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/qe_sim_generator.sv
// Simulated quadrature encoder

`timescale 1ns/1ps
`default_nettype none

`include "qe_config.svh"

module qe_sim_generator
    import qe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     sim_enable,
    input  logic     sim_dir,
    input  qe_word_t phase_time,
    input  qe_word_t counts_per_rev,
    output logic     sim_a,
    output logic     sim_b,
    output logic     sim_i
);

    localparam int PHASE_W = $clog2(`QE_NUM_PHASES);

    logic [PHASE_W-1:0] phase;
    qe_word_t           phase_timer;
    qe_word_t           step_cnt;
    logic               advance;
    logic               rev_done;

    // >= so a shortened phase_time never lets the timer run away
    assign advance  = sim_enable && (phase_timer >= phase_time);
    assign rev_done = (step_cnt == counts_per_rev - 1'b1);

    ////////////////////////////////////////////////////////////////////////////
    // phase timer, phase and step counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase       <= '0;
            phase_timer <= '0;
            step_cnt    <= '0;
            sim_i       <= 1'b0;
        end else if (sim_enable) begin
            if (advance) begin
                phase_timer <= '0;
                // reverse runs the phase sequence backwards
                if (sim_dir) begin
                    phase <= phase - 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
                // index high for the whole phase after a full revolution
                if (rev_done) begin
                    step_cnt <= '0;
                    sim_i    <= 1'b1;
                end else begin
                    step_cnt <= step_cnt + 1'b1;
                    sim_i    <= 1'b0;
                end
            end else begin
                phase_timer <= phase_timer + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // phase to AB: 0 -> 00, 1 -> 10, 2 -> 11, 3 -> 01
    ////////////////////////////////////////////////////////////////////////////

    assign sim_a = phase[1] ^ phase[0];
    assign sim_b = phase[1];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the quadrature encoder channel testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module qe_channel_tb \
    -f files.f -o qe_channel_sim || { echo "build failed"; exit 1; }

./obj_dir/qe_channel_sim > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
